// ==== Bender.yml ====
package:
  name: reduction_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - reducer_data_pkg.sv
      - reducer_port_pkg.sv
      - delay_line.sv
      - addend_bank.sv
      - add_reducer.sv
      - result_holder.sv
      - reduction_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_reduction_unit.sv

// ==== add_reducer.sv ====
// ---------------------------------------
// Pipelined tree of eight addends, one sum out every cycle
// Result appears five edges after the bank value, wrapping at word width
// ---------------------------------------

`timescale 1ns/1ps

`include "add_reducer_config.svh"

module add_reducer (
    input  logic                    clock,
    input  logic                    arst_n,
    input  reducer_data_pkg::bank_t addends,
    output reducer_data_pkg::word_t reduction
);

    localparam int W = `RDC_WORD_WIDTH;

    // Bank value after the input stage
    reducer_data_pkg::bank_t staged;

    // Single word left after the last adder layer
    reducer_data_pkg::word_t tree_sum;

    // ---------------------------------------
    // Input stage
    // ---------------------------------------

    // One register ahead of the tree so the adders see a stable bank
    delay_line #(
        .DEPTH (1),
        .WIDTH ($bits(reducer_data_pkg::bank_t))
    ) u_input_stage (
        .clock    (clock),
        .arst_n   (arst_n),
        .in_data  (addends),
        .out_data (staged)
    );

    // ---------------------------------------
    // Adder layers
    // ---------------------------------------

    generate
        for (genvar l = 0; l < `RDC_TREE_DEPTH; l++) begin : g_layer
            // Words produced by this layer, half of what comes in
            localparam int N_OUT = `RDC_ADDENDS >> (l + 1);

            logic [(2 * N_OUT * W)-1:0] operands;
            logic [(N_OUT * W)-1:0]     sums;

            // The first layer reads the staged bank, later ones the previous layer
            if (l == 0) begin : g_first
                assign operands = staged;
            end else begin : g_next
                assign operands = g_layer[l-1].sums;
            end

            // Word j of the low half pairs with word j of the high half
            // Carry-out is dropped, so each partial sum wraps at W bits
            always_ff @(posedge clock or negedge arst_n) begin
                if (!arst_n) begin
                    sums <= '0;
                end else begin
                    for (int j = 0; j < N_OUT; j++) begin
                        sums[j*W +: W] <= operands[j*W +: W] + operands[(j+N_OUT)*W +: W];
                    end
                end
            end
        end
    endgenerate

    assign tree_sum = g_layer[`RDC_TREE_DEPTH-1].sums;

    // ---------------------------------------
    // Output stage
    // ---------------------------------------

    // Last register, giving the full five-edge depth
    delay_line #(
        .DEPTH (1),
        .WIDTH (W)
    ) u_output_stage (
        .clock    (clock),
        .arst_n   (arst_n),
        .in_data  (tree_sum),
        .out_data (reduction)
    );

endmodule

// ==== add_reducer_config.svh ====
// ---------------------------------------
// Build-time sizes for the sum engine. The adder tree is fixed at
// eight addends and three layers, so only the word width may change
// ---------------------------------------

`ifndef ADD_REDUCER_CONFIG_SVH
`define ADD_REDUCER_CONFIG_SVH

// Bit width of every addend word and of the final sum
// Sums wrap modulo two to this width and the carry-out is lost
`define RDC_WORD_WIDTH 36

// Number of write ports, which is also the number of bank words
`define RDC_ADDENDS 8

// Adder layers in the tree, each one halves the word count
// This must stay the base-two log of RDC_ADDENDS
`define RDC_TREE_DEPTH 3

// Clock edges from the commit edge to the edge that shows the sum
// Input stage, three adder layers and the output stage
`define RDC_LATENCY 5

`endif

// ==== addend_bank.sv ====
// ---------------------------------------
// Eight addend words, a write on a port wins over clear for that port
// ---------------------------------------

`timescale 1ns/1ps

`include "add_reducer_config.svh"

module addend_bank (
    input  logic                    clock,
    input  logic                    arst_n,
    input  reducer_port_pkg::wren_t wren,
    input  reducer_data_pkg::bank_t wdata,
    input  logic                    clear,
    output reducer_data_pkg::bank_t addends
);

    // Width of one slice of the packed bank
    localparam int W = `RDC_WORD_WIDTH;

    // ---------------------------------------
    // Bank update
    // ---------------------------------------

    // This is the only state that survives from one sum to the next
    // A write becomes visible on addends one edge after it is sampled
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            addends <= '0;
        end else begin
            for (int p = 0; p < `RDC_ADDENDS; p++) begin
                if (wren[p]) begin
                    // Port p loads its own slice of wdata
                    addends[p*W +: W] <= wdata[p*W +: W];
                end else if (clear) begin
                    // Clear only reaches ports that are not written this edge
                    addends[p*W +: W] <= '0;
                end
                // With neither write nor clear the word keeps its value
            end
        end
    end

endmodule

// ==== delay_line.sv ====
// ---------------------------------------
// Fixed-depth register chain, every stage resets to zero
// ---------------------------------------

`timescale 1ns/1ps

module delay_line #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 1
) (
    input  logic             clock,
    input  logic             arst_n,
    input  logic [WIDTH-1:0] in_data,
    output logic [WIDTH-1:0] out_data
);

    generate
        if (DEPTH == 0) begin : g_bypass
            // No stages at all, so the input reaches the output in the same cycle
            assign out_data = in_data;
        end else begin : g_chain
            // Stage 0 takes the input, the last stage drives the output
            logic [WIDTH-1:0] stages [DEPTH];

            always_ff @(posedge clock or negedge arst_n) begin
                if (!arst_n) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stages[i] <= '0;
                    end
                end else begin
                    stages[0] <= in_data;
                    // Each stage hands its value one step down the chain per edge
                    for (int i = 1; i < DEPTH; i++) begin
                        stages[i] <= stages[i-1];
                    end
                end
            end

            assign out_data = stages[DEPTH-1];
        end
    endgenerate

endmodule

// ==== list.f ====
+incdir+.
reducer_data_pkg.sv
reducer_port_pkg.sv
delay_line.sv
addend_bank.sv
add_reducer.sv
result_holder.sv
reduction_unit.sv
tb_reduction_unit.sv

// ==== reducer_data_pkg.sv ====
// ---------------------------------------
// Data vector types for the sum engine, sized from the config header
// ---------------------------------------

`include "add_reducer_config.svh"

package reducer_data_pkg;

    // ---------------------------------------
    // Words
    // ---------------------------------------

    // One addend, one partial sum or the final sum
    typedef logic [`RDC_WORD_WIDTH-1:0] word_t;

    // ---------------------------------------
    // Banks
    // ---------------------------------------

    // All addends packed side by side
    // Port 0 sits in the lowest slice, port N at bits N*width and up
    typedef logic [(`RDC_ADDENDS * `RDC_WORD_WIDTH)-1:0] bank_t;

endpackage

// ==== reducer_port_pkg.sv ====
// ---------------------------------------
// Control vector types for the eight write ports
// ---------------------------------------

`include "add_reducer_config.svh"

package reducer_port_pkg;

    // ---------------------------------------
    // Write control
    // ---------------------------------------

    // One enable bit per write port, bit N belongs to port N
    typedef logic [`RDC_ADDENDS-1:0] wren_t;

    // ---------------------------------------
    // Port numbering
    // ---------------------------------------

    // Enough bits to name any one of the eight ports
    // It has to grow by hand if the addend count ever changes
    typedef logic [2:0] port_idx_t;

endpackage

// ==== reduction_testdata.txt ====
# Columns: operation, port, value in hex. Each line is one clock cycle
# Port 8 writes nothing, a test line only names the checks that follow
test latency
write 0 000000001
write 1 000000010
write 2 000000100
write 3 000001000
write 4 000010000
write 5 000100000
write 6 001000000
write 7 010000000
commit 8 0
test partial_update
write 2 0000ABC00
write 5 123456789
commit 8 0
test clear_only
clear 8 0
commit 8 0
test clear_with_write
write 0 00000FFFF
write 6 000777000
clear 3 00000ABCD
commit 8 0
test wrap_around
write 0 FFFFFFFFF
write 1 FFFFFFFFE
write 2 FFFFFFFFD
write 3 FFFFFFFFC
write 4 FFFFFFFFB
write 5 FFFFFFFFA
write 6 FFFFFFFF9
write 7 FFFFFFFF8
commit 8 0
test pipelining
commit 0 000000111
commit 1 000000222
commit 4 000000444
commit 7 FFFFFFFFF
test random
random 0 0
random 1 0
random 2 0
random 3 0
random 4 0
random 5 0
random 6 0
random 7 0
commit 8 0
random 3 0
random 5 0
commit 8 0

// ==== reduction_unit.sv ====
// ---------------------------------------
// Top of the sum engine with no handshake. A commit shows its sum
// on result_valid five edges later, and commits may come every cycle
// ---------------------------------------

`timescale 1ns/1ps

module reduction_unit (
    input  logic                    clock,
    input  logic                    arst_n,
    input  reducer_port_pkg::wren_t wren,
    input  reducer_data_pkg::bank_t wdata,
    input  logic                    clear,
    input  logic                    commit,
    output reducer_data_pkg::word_t result,
    output logic                    result_valid
);

    // Bank contents feeding the tree
    reducer_data_pkg::bank_t addends;

    // Tree output, five edges behind the bank
    reducer_data_pkg::word_t reduction;

    // ---------------------------------------
    // Input side
    // ---------------------------------------

    addend_bank u_addend_bank (
        .clock   (clock),
        .arst_n  (arst_n),
        .wren    (wren),
        .wdata   (wdata),
        .clear   (clear),
        .addends (addends)
    );

    // ---------------------------------------
    // Adder tree
    // ---------------------------------------

    add_reducer u_add_reducer (
        .clock     (clock),
        .arst_n    (arst_n),
        .addends   (addends),
        .reduction (reduction)
    );

    // ---------------------------------------
    // Output side
    // ---------------------------------------

    // Commit goes straight here and is delayed to meet its sum
    result_holder u_result_holder (
        .clock        (clock),
        .arst_n       (arst_n),
        .commit       (commit),
        .reduction    (reduction),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// ==== result_holder.sv ====
// ---------------------------------------
// Holds the committed sum, result_valid marks each new value for one cycle
// ---------------------------------------

`timescale 1ns/1ps

`include "add_reducer_config.svh"

module result_holder (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    commit,
    input  reducer_data_pkg::word_t reduction,
    output reducer_data_pkg::word_t result,
    output logic                    result_valid
);

    // Commit pulse after travelling the pipeline depth
    logic commit_aligned;

    // Sum kept from the most recent valid cycle
    reducer_data_pkg::word_t held_sum;

    // The commit walks the same number of stages as the data it belongs to
    delay_line #(
        .DEPTH (`RDC_LATENCY),
        .WIDTH (1)
    ) u_commit_delay (
        .clock    (clock),
        .arst_n   (arst_n),
        .in_data  (commit),
        .out_data (commit_aligned)
    );

    // The valid flag rises on the same edge that brings the matching sum out of the tree
    // The sum is captured on the next edge, and from then it is held
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            held_sum     <= '0;
        end else begin
            result_valid <= commit_aligned;
            if (result_valid) begin
                held_sum <= reduction;
            end
        end
    end

    // In the valid cycle the fresh sum bypasses the holding register
    assign result = result_valid ? reduction : held_sum;

endmodule

// ==== tb_reduction_unit.sv ====
// ---------------------------------------
// Self-checking testbench run from reduction_testdata.txt, one data line
// per clock cycle. Expected sums come from a bank model kept here
// ---------------------------------------

`timescale 1ns/1ps

`include "add_reducer_config.svh"

module tb_reduction_unit;

    localparam int W          = `RDC_WORD_WIDTH;
    localparam int N          = `RDC_ADDENDS;
    localparam int WAIT_LIMIT = 20;
    localparam int MAX_LINES  = 1000;

    logic                    clock;
    logic                    arst_n;
    reducer_port_pkg::wren_t wren;
    reducer_data_pkg::bank_t wdata;
    logic                    clear;
    logic                    commit;
    reducer_data_pkg::word_t result;
    logic                    result_valid;

    // Reference bank, updated under the same write-over-clear rule
    reducer_data_pkg::word_t model_bank [N];

    // Outstanding commits, oldest first, kept as three parallel queues
    reducer_data_pkg::word_t exp_sum   [$];
    int                      exp_cycle [$];
    logic [8*24-1:0]         exp_name  [$];

    // Sum that result must keep between valid pulses, zero out of reset
    reducer_data_pkg::word_t held_exp;
    logic [8*24-1:0]         held_name;

    int          cycle_count;
    int          results_checked;
    int          value_errors;
    int          timing_errors;
    int          other_errors;
    logic [63:0] rng_state;

    reduction_unit DUT (
        .clock        (clock),
        .arst_n       (arst_n),
        .wren         (wren),
        .wdata        (wdata),
        .clear        (clear),
        .commit       (commit),
        .result       (result),
        .result_valid (result_valid)
    );

    always #5 clock = ~clock;

    // Counts rising edges, so each cycle has a number to compare against
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    // ---------------------------------------
    // Reference model
    // ---------------------------------------

    // 64-bit xorshift step, the low word bits become a random addend
    function automatic logic [63:0] xorshift64(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    // Plain running sum of the model bank, wrapping at the word width
    function automatic reducer_data_pkg::word_t bank_total();
        reducer_data_pkg::word_t acc;
        acc = '0;
        for (int p = 0; p < N; p++) begin
            acc = acc + model_bank[p];
        end
        return acc;
    endfunction

    // Applies one cycle of inputs at the falling edge and holds them until the next one
    task automatic drive_cycle(
        input reducer_port_pkg::wren_t mask,
        input reducer_data_pkg::bank_t data,
        input logic                    clr,
        input logic                    cmt,
        input logic [8*24-1:0]         name
    );
        wren   = mask;
        wdata  = data;
        clear  = clr;
        commit = cmt;
        for (int p = 0; p < N; p++) begin
            if (mask[p]) begin
                model_bank[p] = data[p*W +: W];
            end else if (clr) begin
                model_bank[p] = '0;
            end
        end
        // The commit edge itself counts once, then the pipeline depth follows
        if (cmt) begin
            exp_sum.push_back(bank_total());
            exp_cycle.push_back(cycle_count + `RDC_LATENCY + 1);
            exp_name.push_back(name);
        end
        @(negedge clock);
    endtask

    // ---------------------------------------
    // Result monitor
    // ---------------------------------------

    // Outputs are registered, so they are stable at the falling edge
    always @(negedge clock) begin
        if (arst_n) begin
            if (result_valid) begin
                if (exp_sum.size() == 0) begin
                    $display("Unexpected result_valid pulse in cycle %0d", cycle_count);
                    timing_errors++;
                end else begin
                    if (exp_cycle[0] != cycle_count) begin
                        $display("[FAIL] %0s: valid cycle expected %0d actual %0d",
                                 exp_name[0], exp_cycle[0], cycle_count);
                        timing_errors++;
                    end
                    if (result !== exp_sum[0]) begin
                        $display("[FAIL] %0s: result expected %h actual %h",
                                 exp_name[0], exp_sum[0], result);
                        value_errors++;
                    end
                    results_checked++;
                    held_exp  = exp_sum[0];
                    held_name = exp_name[0];
                    void'(exp_sum.pop_front());
                    void'(exp_cycle.pop_front());
                    void'(exp_name.pop_front());
                end
            end else begin
                // Between pulses the last committed sum stays on result
                if (result !== held_exp) begin
                    $display("[FAIL] %0s: held result expected %h actual %h",
                             held_name, held_exp, result);
                    value_errors++;
                end
                if (exp_sum.size() > 0 && exp_cycle[0] <= cycle_count) begin
                    // Dropping the entry keeps later results lined up with their commits
                    $display("Missing result_valid pulse for %0s in cycle %0d",
                             exp_name[0], exp_cycle[0]);
                    timing_errors++;
                    void'(exp_sum.pop_front());
                    void'(exp_cycle.pop_front());
                    void'(exp_name.pop_front());
                end
            end
        end
    end

    // ---------------------------------------
    // Stimulus
    // ---------------------------------------

    initial begin
        int                      fd;
        int                      line_count;
        int                      fields;
        int                      port;
        int                      waited;
        logic [8*128-1:0]        line;
        logic [8*8-1:0]          op;
        logic [8*24-1:0]         test_name;
        reducer_data_pkg::word_t value;
        reducer_port_pkg::wren_t mask;
        reducer_data_pkg::bank_t data;
        logic                    clr;
        logic                    cmt;

        clock           = 1'b0;
        arst_n          = 1'b0;
        wren            = '0;
        wdata           = '0;
        clear           = 1'b0;
        commit          = 1'b0;
        cycle_count     = 0;
        results_checked = 0;
        value_errors    = 0;
        timing_errors   = 0;
        other_errors    = 0;
        rng_state       = 64'd55;
        test_name       = "none";
        held_exp        = '0;
        held_name       = "reset";
        for (int p = 0; p < N; p++) begin
            model_bank[p] = '0;
        end

        repeat (2) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        fd = $fopen("reduction_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open reduction_testdata.txt");
            other_errors++;
        end else begin
            line_count = 0;
            while (line_count < MAX_LINES && $fgets(line, fd) != 0) begin
                line_count++;
                op     = '0;
                fields = $sscanf(line, "%s", op);
                if (fields < 1 || op == "#") begin
                    // Blank line or comment, no cycle is spent
                end else if (op == "test") begin
                    test_name = '0;
                    fields    = $sscanf(line, "%s %s", op, test_name);
                end else begin
                    port   = N;
                    value  = '0;
                    fields = $sscanf(line, "%s %d %h", op, port, value);
                    mask   = '0;
                    // Slices of ports that are not written carry ones, which must be ignored
                    data   = '1;
                    clr    = 1'b0;
                    cmt    = 1'b0;
                    if (op == "random") begin
                        rng_state = xorshift64(rng_state);
                        value     = rng_state[W-1:0];
                    end else if (op == "clear") begin
                        clr = 1'b1;
                    end else if (op == "commit") begin
                        cmt = 1'b1;
                    end else if (op != "write") begin
                        $display("Unknown operation on data line %0d", line_count);
                        other_errors++;
                    end
                    if (port >= 0 && port < N) begin
                        mask[port]         = 1'b1;
                        data[port*W +: W]  = value;
                    end
                    drive_cycle(mask, data, clr, cmt, test_name);
                end
            end
            $fclose(fd);
        end

        wren   = '0;
        clear  = 1'b0;
        commit = 1'b0;

        // Wait for the sums still in the pipeline
        waited = 0;
        while (exp_sum.size() > 0 && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (exp_sum.size() > 0) begin
            $display("Timed out after %0d cycles with %0d results outstanding",
                     WAIT_LIMIT, exp_sum.size());
            other_errors++;
        end

        // Idle cycles so that a stray extra pulse is still seen
        repeat (4) @(negedge clock);

        if (results_checked == 0) begin
            $display("No results were checked, the data file gave no commit");
            other_errors++;
        end

        $display("Errors: %0d value, %0d timing, %0d other, %0d results checked",
                 value_errors, timing_errors, other_errors, results_checked);
        if (value_errors + timing_errors + other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
